//--- Bender.yml
package:
  name: riscv_pipe

sources:
  - hdl/riscv_pipe_pkg.sv
  - hdl/riscv_pipe_alu.sv
  - hdl/riscv_pipe_regfile.sv
  - hdl/riscv_pipe_fetch.sv
  - hdl/riscv_pipe_decode.sv
  - hdl/riscv_pipe_execute.sv
  - hdl/riscv_pipe_memwb.sv
  - hdl/riscv_pipe_top.sv
  - target: test
    files:
      - bench/riscv_pipe_clkgen.sv
      - bench/riscv_pipe_asserts.sv
      - bench/riscv_pipe_tb.sv

//--- bench/riscv_pipe_asserts.sv
/*
  Concurrent checks on the pipeline top level, bound into every instance.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_asserts (
  input logic                    clk,
  input logic                    reset,
  input logic                    stall,
  input riscv_pipe_pkg::word_t   imem_addr,
  input riscv_pipe_pkg::retire_t retire
);
  import riscv_pipe_pkg::*;

  int fail_count = 0;  // Failures seen so far

  // ----------------------------------------
  // Fetch side
  // ----------------------------------------
  pc_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("imem_addr is not word aligned");
    end

  pc_holds_on_stall: assert property (@(posedge clk) disable iff (reset)
                                      stall |=> $stable(imem_addr))
    else begin
      fail_count++;
      $error("imem_addr moved during a stall");
    end

  // Retire side
  no_x0_write: assert property (@(posedge clk) disable iff (reset)
                                retire.valid |-> retire.rd != '0)
    else begin
      fail_count++;
      $error("retire wrote x0");
    end

  quiet_in_reset: assert property (@(posedge clk) reset |=> !retire.valid)
    else begin
      fail_count++;
      $error("retire strobe while in reset");
    end

endmodule

bind riscv_pipe_top riscv_pipe_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .stall     (stall),
  .imem_addr (imem_addr),
  .retire    (retire)
);

`default_nettype wire

//--- bench/riscv_pipe_clkgen.sv
/*
  Free-running testbench clock, starts low.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_clkgen #(
  parameter real PERIOD = 4.0  // ns
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD / 2.0) clk = ~clk;  // Half period per toggle

endmodule

`default_nettype wire

//--- bench/riscv_pipe_tb.sv
/*
  Testbench of the RV32I pipeline. Runs a seeded random program from memory models
  and checks every retire and store against an in-order ISA model.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_tb;
  import riscv_pipe_pkg::*;

  localparam word_t      RESET_VECTOR   = 32'h0008_0000;
  localparam int         prog_len       = 200;
  localparam int         retire_timeout = 40;  // Cycles allowed between retires
  localparam int         drain_cycles   = 20;
  localparam word_t      nop            = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [6:0] opc_reg        = 7'h33;
  localparam logic [6:0] opc_imm        = 7'h13;
  localparam logic [6:0] opc_lui        = 7'h37;
  localparam logic [6:0] opc_auipc      = 7'h17;
  localparam logic [6:0] opc_load       = 7'h03;
  localparam logic [6:0] opc_store      = 7'h23;

  logic      clk;
  logic      reset;
  word_t     imem_data  = '0;
  word_t     dmem_rdata = '0;
  word_t     imem_addr;
  dmem_req_t dmem_req;
  retire_t   retire;

  integer    seed = 32'h2f98fbd0;
  word_t     prog [0:prog_len-1];
  word_t     dmem [0:255];        // DUT side data memory
  word_t     model_mem [0:255];   // ISA model copy
  word_t     read_hold = '0;      // Load word waiting for its memory cycle
  retire_t   exp_retires [$];
  dmem_req_t exp_stores [$];
  int        cycle = 0;
  int        store_count = 0;
  int        retire_errors = 0;
  int        store_errors = 0;
  int        event_errors = 0;

  riscv_pipe_clkgen #(.PERIOD(4.0)) u_clkgen (.clk(clk));

  riscv_pipe_top #(
    .RESET_VECTOR (RESET_VECTOR)
  ) UUT (
    .clk        (clk),
    .reset      (reset),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .retire     (retire)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------
  function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], opc_store};  // SW off x0
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // Program: AUIPC, 30 independent ADDIs to fill x2..x31, then random ops
  task automatic build_program();
    reg_addr_t   rd, rs1, rs2, last_rd;
    logic [2:0]  f3;
    logic [11:0] imm, last_st;
    int unsigned width;
    bit          have_st;
    int          i;
    prog[0] = enc_u(20'(pick(1 << 20)), 5'd1, opc_auipc);
    for (i = 1; i < 31; i++) prog[i] = enc_i(12'(pick(4096)), 5'd0, 3'b000,
                                              reg_addr_t'(i + 1), opc_imm);
    last_rd = 5'd31;
    last_st = '0;
    have_st = 1'b0;
    for (i = 31; i < prog_len; i++) begin
      rd  = reg_addr_t'(pick(32));
      rs1 = (pick(2) != 0) ? last_rd : reg_addr_t'(pick(32));  // Bias to dependence
      rs2 = (pick(2) != 0) ? last_rd : reg_addr_t'(pick(32));
      f3  = 3'(pick(8));
      case (pick(8))
        0, 1: prog[i] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && pick(2) != 0) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd);
        2, 3: begin
          imm = 12'(pick(4096));
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};  // SLLI
          if (f3 == 3'd5) imm = {(pick(2) != 0) ? 7'h20 : 7'h00, imm[4:0]};  // SRLI/SRAI
          prog[i] = enc_i(imm, rs1, f3, rd, opc_imm);
        end
        4: prog[i] = enc_u(20'(pick(1 << 20)), rd, (pick(2) != 0) ? opc_lui : opc_auipc);
        5, 6: begin
          case (pick(5))
            0: f3 = 3'b000;  // LB
            1: f3 = 3'b100;  // LBU
            2: f3 = 3'b001;  // LH
            3: f3 = 3'b101;  // LHU
            default: f3 = 3'b010;
          endcase
          width = f3[1] ? 4 : (f3[0] ? 2 : 1);
          if (have_st && pick(2) != 0)
            imm = last_st + 12'(pick(4));  // Read back a stored word
          else
            imm = 12'(pick(1024));
          imm = imm & ~12'(width - 1);
          prog[i] = enc_i(imm, 5'd0, f3, rd, opc_load);
        end
        default: begin
          last_st = 12'(pick(1024)) & 12'hffc;
          have_st = 1'b1;
          prog[i] = enc_s(last_st, rs2);
          rd      = last_rd;  // Writes nothing, keep the chain
        end
      endcase
      last_rd = rd;
    end
  endtask

  // ----------------------------------------
  // ISA model
  // ----------------------------------------
  function automatic word_t alu_model(input logic [2:0] f3, input logic neg,
                                      input logic arith, input word_t a, input word_t b);
    case (f3)
      3'd0: return neg ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (arith) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic run_model();
    word_t      r [0:31];
    word_t      pc, inst, val, addr, imm_i, imm_s, imm_u;
    reg_addr_t  rd, rs1, rs2;
    logic [2:0] f3;
    bit         writes;
    int         i;
    for (i = 0; i < 32; i++) r[i] = '0;
    for (i = 0; i < prog_len; i++) begin
      pc     = RESET_VECTOR + 32'(4 * i);
      inst   = prog[i];
      rd     = inst[11:7];
      f3     = inst[14:12];
      rs1    = inst[19:15];
      rs2    = inst[24:20];
      imm_i  = {{20{inst[31]}}, inst[31:20]};
      imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      imm_u  = {inst[31:12], 12'h000};
      writes = 1'b1;
      val    = '0;
      case (inst[6:0])
        opc_reg:   val = alu_model(f3, inst[30], inst[30], r[rs1], r[rs2]);
        opc_imm:   val = alu_model(f3, 1'b0, inst[30], r[rs1], imm_i);
        opc_lui:   val = imm_u;
        opc_auipc: val = pc + imm_u;
        opc_load: begin
          addr = r[rs1] + imm_i;
          val  = model_mem[addr[9:2]] >> (8 * addr[1:0]);  // Addressed byte to bit 0
          case (f3)
            3'b000:  val = {{24{val[7]}}, val[7:0]};
            3'b100:  val = {24'h0, val[7:0]};
            3'b001:  val = {{16{val[15]}}, val[15:0]};
            3'b101:  val = {16'h0, val[15:0]};
            default: ;
          endcase
        end
        opc_store: begin
          writes = 1'b0;
          addr   = r[rs1] + imm_s;
          exp_stores.push_back(dmem_req_t'{valid: 1'b1, write: 1'b1, addr: addr,
                                           wdata: r[rs2]});
          model_mem[addr[9:2]] = r[rs2];
        end
        default:   writes = 1'b0;
      endcase
      if (writes && rd != 0) begin
        r[rd] = val;
        exp_retires.push_back(retire_t'{valid: 1'b1, rd: rd, data: val});
      end
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      retire_errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      retire_errors++;
      $display("Error %s: expected x%0d, actual x%0d", name, exp, act);
    end
  endtask

  task automatic check_store(input string name, input dmem_req_t exp, input dmem_req_t act);
    if (act !== exp) begin
      store_errors++;
      $display("Error %s: expected addr %h data %h, actual addr %h data %h write %b",
               name, exp.addr, exp.wdata, act.addr, act.wdata, act.write);
    end
  endtask

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = (addr - RESET_VECTOR) >> 2;
    if (addr >= RESET_VECTOR && idx < prog_len) return prog[idx];
    return nop;  // Past the program
  endfunction

  // Memory models, driven on the falling edge
  always @(negedge clk) begin
    imem_data  <= fetch_word(imem_addr);
    dmem_rdata <= read_hold;  // Word read one cycle back
    if (!reset && dmem_req.valid) begin
      if (dmem_req.write) begin
        if (exp_stores.size() == 0) begin
          store_errors++;
          $display("Unexpected store of %h to %h", dmem_req.wdata, dmem_req.addr);
        end else begin
          check_store($sformatf("store %0d", store_count), exp_stores.pop_front(), dmem_req);
        end
        store_count++;
        dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
      end else begin
        read_hold = dmem[dmem_req.addr[9:2]];
      end
    end
  end

  task automatic wait_retire(output bit got);
    int waited;
    got = 1'b0;
    for (waited = 0; waited < retire_timeout && !got; waited++) begin
      @(negedge clk);
      got = retire.valid;
    end
  endtask

  initial begin
    int n;
    int i;
    int t_start;
    int t_prev;
    bit got;
    reset = 1'b1;
    build_program();
    for (i = 0; i < 256; i++) begin
      dmem[i]      = $random(seed);  // Random preset
      model_mem[i] = dmem[i];
    end
    run_model();

    repeat (10) @(posedge clk);
    @(negedge clk);
    check_word("reset vector", RESET_VECTOR, imem_addr);
    reset   = 1'b0;
    t_start = cycle;  // First PC is on imem_addr now
    t_prev  = cycle;
    for (n = 0; n < exp_retires.size(); n++) begin
      wait_retire(got);
      if (!got) begin
        event_errors++;
        $display("Timeout waiting for retire %0d of %0d", n, exp_retires.size());
        break;
      end
      check_reg($sformatf("retire %0d rd", n), exp_retires[n].rd, retire.rd);
      check_word(n == 0 ? "first auipc" : $sformatf("retire %0d data", n),
                 exp_retires[n].data, retire.data);
      if (n == 0)
        check_word("first retire latency", 32'd4, word_t'(cycle - t_start));
      else if (n <= 30)
        check_word($sformatf("prologue retire %0d gap", n), 32'd1, word_t'(cycle - t_prev));
      t_prev = cycle;
    end

    if (n == exp_retires.size()) begin
      for (i = 0; i < drain_cycles; i++) begin
        @(negedge clk);
        if (retire.valid) begin
          event_errors++;
          $display("Unexpected retire of x%0d after the program", retire.rd);
        end
      end
    end
    if (exp_stores.size() != 0) begin
      event_errors++;
      $display("%0d expected stores never reached the data port", exp_stores.size());
    end

    $display("Errors: retire %0d, store %0d, sequence %0d, assertion %0d",
             retire_errors, store_errors, event_errors, UUT.u_asserts.fail_count);
    if (retire_errors + store_errors + event_errors + UUT.u_asserts.fail_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_alu.sv
/*
  Combinational ALU of the execute stage, eleven functions.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_alu (
  input  riscv_pipe_pkg::word_t   in0,
  input  riscv_pipe_pkg::word_t   in1,
  input  riscv_pipe_pkg::alu_fn_e fn,
  output riscv_pipe_pkg::word_t   result
);
  import riscv_pipe_pkg::*;

  logic [4:0] shamt;

  assign shamt = in1[4:0];  // Only low 5 bits shift

  always_comb begin
    case (fn)
      alu_add:    result = in0 + in1;
      alu_sub:    result = in0 - in1;
      alu_sll:    result = in0 << shamt;
      alu_or:     result = in0 | in1;
      alu_lt:     result = {31'b0, $signed(in0) < $signed(in1)};
      alu_ltu:    result = {31'b0, in0 < in1};
      alu_and:    result = in0 & in1;
      alu_xor:    result = in0 ^ in1;
      alu_srl:    result = in0 >> shamt;
      alu_sra:    result = $signed(in0) >>> shamt;  // Sign fill
      alu_pass_b: result = in1;                     // LUI immediate
      default:    result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_decode.sv
/*
  Decode stage. Parses the instruction, decodes its controls, selects
  operands, interlocks on RAW hazards and registers the decode/execute bundle.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  riscv_pipe_pkg::fd_t       fd,
  input  riscv_pipe_pkg::word_t     rs1_data,
  input  riscv_pipe_pkg::word_t     rs2_data,
  input  riscv_pipe_pkg::dest_t     x_dest,    // Producer in execute
  input  riscv_pipe_pkg::dest_t     m_dest,    // Producer in memory
  output riscv_pipe_pkg::reg_addr_t rs1_addr,
  output riscv_pipe_pkg::reg_addr_t rs2_addr,
  output logic                      stall,
  output riscv_pipe_pkg::dx_t       dx
);
  import riscv_pipe_pkg::*;

  localparam logic [6:0] op_reg   = 7'b0110011;
  localparam logic [6:0] op_imm   = 7'b0010011;
  localparam logic [6:0] op_lui   = 7'b0110111;
  localparam logic [6:0] op_auipc = 7'b0010111;
  localparam logic [6:0] op_load  = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;                    // funct7 bit 5, SUB and SRA
  reg_addr_t  rd;
  word_t      imm_i, imm_s, imm_u;
  logic       legal, wen, use_rs1, use_rs2;
  alu_fn_e    alu_fn;
  op0_sel_e   op0_sel;
  op1_sel_e   op1_sel;
  mem_op_e    mem_op;
  load_kind_e load_kind;
  word_t      imm, op0, op1;

  // Shared by register and immediate ALU ops
  function automatic alu_fn_e alu_from_f3(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  return sub ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_lt;
      3'b011:  return alu_ltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic logic raw_hit(input reg_addr_t src, input dest_t d);
    return d.en && (d.addr == src) && (src != '0);  // x0 never hazards
  endfunction

  // Field parse
  assign opcode   = fd.inst[6:0];
  assign rd       = fd.inst[11:7];
  assign funct3   = fd.inst[14:12];
  assign rs1_addr = fd.inst[19:15];
  assign rs2_addr = fd.inst[24:20];
  assign alt      = fd.inst[30];
  assign imm_i    = {{20{fd.inst[31]}}, fd.inst[31:20]};
  assign imm_s    = {{20{fd.inst[31]}}, fd.inst[31:25], fd.inst[11:7]};
  assign imm_u    = {fd.inst[31:12], 12'b0};

  // ----------------------------------------
  // Control decode
  // ----------------------------------------
  always_comb begin
    legal     = 1'b1;
    wen       = 1'b1;
    use_rs1   = 1'b1;
    use_rs2   = 1'b0;
    alu_fn    = alu_add;
    op0_sel   = op0_rs1;
    op1_sel   = op1_imm;
    imm       = imm_i;
    mem_op    = mem_none;
    load_kind = ld_w;
    case (opcode)
      op_reg: begin
        use_rs2 = 1'b1;
        op1_sel = op1_rs2;
        alu_fn  = alu_from_f3(funct3, alt);
      end
      op_imm:   alu_fn = alu_from_f3(funct3, 1'b0);  // Shamt rides in imm_i
      op_lui: begin
        use_rs1 = 1'b0;
        op0_sel = op0_zero;
        imm     = imm_u;
        alu_fn  = alu_pass_b;
      end
      op_auipc: begin
        use_rs1 = 1'b0;
        op0_sel = op0_pc;
        imm     = imm_u;
      end
      op_load: begin
        mem_op = mem_load;
        case (funct3)
          3'b000:  load_kind = ld_b;
          3'b001:  load_kind = ld_h;
          3'b010:  load_kind = ld_w;
          3'b100:  load_kind = ld_bu;
          3'b101:  load_kind = ld_hu;
          default: legal = 1'b0;
        endcase
      end
      op_store: begin
        wen     = 1'b0;
        use_rs2 = 1'b1;
        imm     = imm_s;
        mem_op  = mem_store;
        legal   = (funct3 == 3'b010);  // SW only
      end
      default:  legal = 1'b0;  // Becomes a bubble
    endcase
  end

  // Operand muxes
  assign op0 = (op0_sel == op0_rs1) ? rs1_data :
               (op0_sel == op0_pc)  ? fd.pc    : '0;
  assign op1 = (op1_sel == op1_rs2) ? rs2_data : imm;

  // RAW interlock, writeback is covered by the register file bypass
  assign stall = fd.valid && legal &&
                 ((use_rs1 && (raw_hit(rs1_addr, x_dest) || raw_hit(rs1_addr, m_dest))) ||
                  (use_rs2 && (raw_hit(rs2_addr, x_dest) || raw_hit(rs2_addr, m_dest))));

  // Decode/execute register, bubble while stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      dx.valid <= 1'b0;
    end else begin
      dx <= '{valid: fd.valid && legal && !stall, pc: fd.pc, op0: op0, op1: op1,
              store_data: rs2_data, alu_fn: alu_fn, mem_op: mem_op,
              load_kind: load_kind, dest: '{en: wen && (rd != '0), addr: rd}};
    end
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_execute.sv
/*
  Execute stage. Runs the ALU, issues the data memory request for loads
  and stores, and registers the execute/memory bundle.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_execute (
  input  logic                      clk,
  input  logic                      reset,
  input  riscv_pipe_pkg::dx_t       dx,
  output riscv_pipe_pkg::dest_t     x_dest,
  output riscv_pipe_pkg::dmem_req_t dmem_req,
  output riscv_pipe_pkg::xm_t       xm
);
  import riscv_pipe_pkg::*;

  word_t alu_out;

  riscv_pipe_alu u_alu (
    .in0    (dx.op0),
    .in1    (dx.op1),
    .fn     (dx.alu_fn),
    .result (alu_out)
  );

  // Destination for the decode interlock, bubbles write nothing
  assign x_dest = '{en: dx.valid && dx.dest.en, addr: dx.dest.addr};

  // ----------------------------------------
  // Data request, response lands in memory
  // ----------------------------------------
  assign dmem_req = '{
    valid: dx.valid && (dx.mem_op != mem_none),
    write: dx.mem_op == mem_store,
    addr:  alu_out,        // rs1 + offset
    wdata: dx.store_data
  };

  // Execute/memory register
  always_ff @(posedge clk) begin
    if (reset) begin
      xm.valid <= 1'b0;
    end else begin
      xm <= '{valid: dx.valid, result: alu_out, offset: alu_out[1:0],
              mem_op: dx.mem_op, load_kind: dx.load_kind, dest: dx.dest};
    end
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_fetch.sv
/*
  Fetch stage. Holds the PC, drives the instruction address and
  registers each fetched instruction with its PC for decode.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_fetch #(
  parameter riscv_pipe_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stall,      // Decode interlock
  input  riscv_pipe_pkg::word_t imem_data,  // Combinational from memory
  output riscv_pipe_pkg::word_t imem_addr,
  output riscv_pipe_pkg::fd_t   fd
);
  import riscv_pipe_pkg::*;

  word_t pc;

  assign imem_addr = pc;  // PC goes straight out

  // PC and fetch/decode register move together
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= RESET_VECTOR;
      fd.valid <= 1'b0;
    end else if (!stall) begin
      pc <= pc + 32'd4;  // No branches, so always sequential
      fd <= '{valid: 1'b1, pc: pc, inst: imem_data};
    end
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_memwb.sv
/*
  Memory stage and writeback register. Aligns and extends load data,
  picks the writeback value and drives the retire record.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_memwb (
  input  logic                    clk,
  input  logic                    reset,
  input  riscv_pipe_pkg::xm_t     xm,
  input  riscv_pipe_pkg::word_t   dmem_rdata,  // Word read at the issue edge
  output riscv_pipe_pkg::dest_t   m_dest,
  output riscv_pipe_pkg::retire_t retire
);
  import riscv_pipe_pkg::*;

  word_t shifted;
  word_t load_val;
  word_t wb_data;

  // Addressed byte down to bit 0
  assign shifted = dmem_rdata >> {xm.offset, 3'b000};

  // ----------------------------------------
  // Subword extension
  // ----------------------------------------
  always_comb begin
    case (xm.load_kind)
      ld_b:    load_val = {{24{shifted[7]}}, shifted[7:0]};
      ld_bu:   load_val = {24'b0, shifted[7:0]};
      ld_h:    load_val = {{16{shifted[15]}}, shifted[15:0]};
      ld_hu:   load_val = {16'b0, shifted[15:0]};
      default: load_val = shifted;  // Full word
    endcase
  end

  // Writeback mux
  assign wb_data = (xm.mem_op == mem_load) ? load_val : xm.result;

  // Interlock sees the instruction sitting here
  assign m_dest = '{en: xm.valid && xm.dest.en, addr: xm.dest.addr};

  // Memory/writeback register, doubles as the register file write
  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire <= '{valid: xm.valid && xm.dest.en,  // Stores and bubbles stay quiet
                  rd: xm.dest.addr, data: wb_data};
    end
  end

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_pkg.sv
/*
  Shared types for the five-stage RV32I pipeline.
  Stage modules import it inside their bodies and name its types in their ports.
*/
`default_nettype none

package riscv_pipe_pkg;

  // ----------------------------------------
  // Plain vector types
  // ----------------------------------------
  typedef logic [31:0] word_t;      // Data or address word
  typedef logic [4:0]  reg_addr_t;  // Register specifier

  // ----------------------------------------
  // Control encodings
  // ----------------------------------------
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_or,
    alu_lt,      // Signed set-less-than
    alu_ltu,     // Unsigned set-less-than
    alu_and,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_pass_b   // LUI
  } alu_fn_e;

  typedef enum logic [1:0] {
    op0_rs1,
    op0_pc,      // AUIPC
    op0_zero
  } op0_sel_e;

  typedef enum logic {
    op1_rs2,
    op1_imm
  } op1_sel_e;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_e;

  typedef enum logic [2:0] {
    ld_w,
    ld_b,
    ld_bu,
    ld_h,
    ld_hu
  } load_kind_e;

  // ----------------------------------------
  // Stage bundles
  // ----------------------------------------
  typedef struct packed {
    logic      en;    // Writes a register
    reg_addr_t addr;
  } dest_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fd_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    word_t      op0;         // ALU input 0
    word_t      op1;         // ALU input 1
    word_t      store_data;  // rs2 value for SW
    alu_fn_e    alu_fn;
    mem_op_e    mem_op;
    load_kind_e load_kind;
    dest_t      dest;
  } dx_t;

  typedef struct packed {
    logic       valid;
    word_t      result;      // ALU result, also the data address
    logic [1:0] offset;      // Byte within the word
    mem_op_e    mem_op;
    load_kind_e load_kind;
    dest_t      dest;
  } xm_t;

  typedef struct packed {
    logic      valid;        // One strobe per register write
    reg_addr_t rd;
    word_t     data;
  } retire_t;

  typedef struct packed {
    logic  valid;
    logic  write;            // Store when set, load otherwise
    word_t addr;
    word_t wdata;
  } dmem_req_t;

endpackage

`default_nettype wire

//--- hdl/riscv_pipe_regfile.sv
/*
  Integer register file, 31 writable registers with x0 tied to zero.
  Two combinational reads, one write that bypasses to the reads.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_regfile (
  input  logic                      clk,
  input  riscv_pipe_pkg::reg_addr_t rs1_addr,
  input  riscv_pipe_pkg::reg_addr_t rs2_addr,
  input  riscv_pipe_pkg::retire_t   wr,
  output riscv_pipe_pkg::word_t     rs1_data,
  output riscv_pipe_pkg::word_t     rs2_data
);
  import riscv_pipe_pkg::*;

  word_t regs [1:31];

  // Same logic for both ports, new data wins on a same-cycle write
  function automatic word_t read_port(input reg_addr_t a);
    if (a == '0) return '0;
    if (wr.valid && (wr.rd == a)) return wr.data;
    return regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (wr.valid && (wr.rd != '0)) begin
      regs[wr.rd] <= wr.data;
    end
  end

  always_comb rs1_data = read_port(rs1_addr);
  always_comb rs2_data = read_port(rs2_addr);

endmodule

`default_nettype wire

//--- hdl/riscv_pipe_top.sv
/*
  Top level of the RV32I pipeline. Chains fetch, decode, execute and
  memory/writeback around the register file, with separate memory ports.
*/
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_top #(
  parameter riscv_pipe_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic                      clk,
  input  logic                      reset,
  input  riscv_pipe_pkg::word_t     imem_data,
  input  riscv_pipe_pkg::word_t     dmem_rdata,
  output riscv_pipe_pkg::word_t     imem_addr,
  output riscv_pipe_pkg::dmem_req_t dmem_req,
  output riscv_pipe_pkg::retire_t   retire
);
  import riscv_pipe_pkg::*;

  // ----------------------------------------
  // Stage links
  // ----------------------------------------
  fd_t       fd;
  dx_t       dx;
  xm_t       xm;
  dest_t     x_dest, m_dest;  // Interlock sources
  logic      stall;
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;

  riscv_pipe_fetch #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_fetch (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .imem_data (imem_data),
    .imem_addr (imem_addr),
    .fd        (fd)
  );

  riscv_pipe_decode u_decode (
    .clk      (clk),
    .reset    (reset),
    .fd       (fd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .x_dest   (x_dest),
    .m_dest   (m_dest),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .stall    (stall),
    .dx       (dx)
  );

  riscv_pipe_execute u_execute (
    .clk      (clk),
    .reset    (reset),
    .dx       (dx),
    .x_dest   (x_dest),
    .dmem_req (dmem_req),
    .xm       (xm)
  );

  riscv_pipe_memwb u_memwb (
    .clk        (clk),
    .reset      (reset),
    .xm         (xm),
    .dmem_rdata (dmem_rdata),
    .m_dest     (m_dest),
    .retire     (retire)
  );

  // Retire record is the write port
  riscv_pipe_regfile u_regfile (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr       (retire),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

//--- riscv_pipe.f
hdl/riscv_pipe_pkg.sv
hdl/riscv_pipe_alu.sv
hdl/riscv_pipe_regfile.sv
hdl/riscv_pipe_fetch.sv
hdl/riscv_pipe_decode.sv
hdl/riscv_pipe_execute.sv
hdl/riscv_pipe_memwb.sv
hdl/riscv_pipe_top.sv
bench/riscv_pipe_clkgen.sv
bench/riscv_pipe_asserts.sv
bench/riscv_pipe_tb.sv
